// ==== verilog/lcd_pkg.sv ====
package lcd_pkg;

    // ####################
    // basic types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] color_t;   // rgb565, high byte first on the wire
    typedef logic [7:0]  coord_t;

    typedef struct packed {
        logic  dc;                  // 1 data, 0 command
        byte_t payload;
    } lcd_word_t;

    typedef enum logic [1:0] {IDLE, INIT, SHOW_PIC, DRAW_LINE} lcd_phase_e;

    // ####################
    // st7789 commands
    localparam byte_t CMD_SWRESET  = 8'h01;
    localparam byte_t CMD_SLPOUT   = 8'h11;
    localparam byte_t CMD_COLMOD   = 8'h3A;
    localparam byte_t CMD_DISPON   = 8'h29;
    localparam byte_t CMD_CASET    = 8'h2A;
    localparam byte_t CMD_RASET    = 8'h2B;
    localparam byte_t CMD_RAMWR    = 8'h2C;
    localparam byte_t COLMOD_16BIT = 8'h55;

    // ####################
    // panel geometry, kept tiny for sim
    localparam int     LCD_W      = 8;
    localparam int     LCD_H      = 4;
    localparam coord_t LINE_ROW   = 8'd1;
    localparam coord_t LINE_X0    = 8'd2;
    localparam coord_t LINE_X1    = 8'd5;
    localparam color_t BG_COLOR   = 16'h001F;
    localparam color_t LINE_COLOR = 16'hF800;

    localparam int INIT_LEN   = 5;
    localparam int SETUP_LEN  = 11;   // caset + 4, raset + 4, ramwr
    localparam int PIC_WORDS  = SETUP_LEN + 2 * LCD_W * LCD_H;
    localparam int LINE_WORDS = SETUP_LEN + 2 * (int'(LINE_X1) - int'(LINE_X0) + 1);

endpackage

// ==== verilog/lcd_init.sv ====
`timescale 1ns/1ns

module lcd_init (
    input  logic                sys_clk_50MHz,
    input  logic                sys_rst_n,
    output lcd_pkg::lcd_word_t  word,
    output logic                req,
    input  logic                ack,
    output logic                init_done
);

    typedef enum logic [1:0] {ST_START, ST_REQ, ST_REL, ST_DONE} init_state_e;

    init_state_e state;
    logic [2:0]  idx;

    // command rom
    always_comb begin
        case (idx)
            3'd0:    word = '{dc: 1'b0, payload: lcd_pkg::CMD_SWRESET};
            3'd1:    word = '{dc: 1'b0, payload: lcd_pkg::CMD_SLPOUT};
            3'd2:    word = '{dc: 1'b0, payload: lcd_pkg::CMD_COLMOD};
            3'd3:    word = '{dc: 1'b1, payload: lcd_pkg::COLMOD_16BIT};
            default: word = '{dc: 1'b0, payload: lcd_pkg::CMD_DISPON};
        endcase
    end

    always_ff @(posedge sys_clk_50MHz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= ST_START;
            idx       <= '0;
            req       <= 1'b0;
            init_done <= 1'b0;
        end else begin
            case (state)
                ST_START: begin
                    req   <= 1'b1;
                    state <= ST_REQ;
                end
                ST_REQ: if (ack) begin
                    req   <= 1'b0;
                    state <= ST_REL;
                end
                ST_REL: if (!ack) begin
                    if (idx == 3'(lcd_pkg::INIT_LEN - 1)) begin
                        init_done <= 1'b1;   // sticky until reset
                        state     <= ST_DONE;
                    end else begin
                        idx   <= idx + 3'd1;
                        req   <= 1'b1;
                        state <= ST_REQ;
                    end
                end
                default: state <= ST_DONE;
            endcase
        end
    end

endmodule

// ==== verilog/lcd_show_pic.sv ====
`timescale 1ns/1ns

module lcd_show_pic (
    input  logic                sys_clk_50MHz,
    input  logic                sys_rst_n,
    input  logic                start_pic,
    output lcd_pkg::lcd_word_t  word,
    output logic                req,
    input  logic                ack,
    output logic                pic_done
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_REL} pic_state_e;

    pic_state_e  state;
    logic [6:0]  step;      // setup words, then pixel bytes
    logic [6:0]  pix_idx;

    assign pix_idx = step - 7'(lcd_pkg::SETUP_LEN);

    // ####################
    // word table
    always_comb begin
        word.dc = 1'b1;
        case (step)
            7'd0:    begin word.dc = 1'b0; word.payload = lcd_pkg::CMD_CASET; end
            7'd4:    word.payload = lcd_pkg::byte_t'(lcd_pkg::LCD_W - 1);
            7'd5:    begin word.dc = 1'b0; word.payload = lcd_pkg::CMD_RASET; end
            7'd9:    word.payload = lcd_pkg::byte_t'(lcd_pkg::LCD_H - 1);
            7'd10:   begin word.dc = 1'b0; word.payload = lcd_pkg::CMD_RAMWR; end
            7'd1, 7'd2, 7'd3, 7'd6, 7'd7, 7'd8: word.payload = 8'h00;
            default: word.payload = pix_idx[0] ? lcd_pkg::BG_COLOR[7:0]
                                               : lcd_pkg::BG_COLOR[15:8];
        endcase
    end

    always_ff @(posedge sys_clk_50MHz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= ST_IDLE;
            step     <= '0;
            req      <= 1'b0;
            pic_done <= 1'b0;
        end else begin
            pic_done <= 1'b0;
            case (state)
                ST_IDLE: if (start_pic) begin
                    step  <= '0;
                    req   <= 1'b1;
                    state <= ST_REQ;
                end
                ST_REQ: if (ack) begin
                    req   <= 1'b0;
                    state <= ST_REL;
                end
                ST_REL: if (!ack) begin
                    if (step == 7'(lcd_pkg::PIC_WORDS - 1)) begin
                        pic_done <= 1'b1;
                        state    <= ST_IDLE;
                    end else begin
                        step  <= step + 7'd1;
                        req   <= 1'b1;
                        state <= ST_REQ;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/lcd_draw_line.sv ====
`timescale 1ns/1ns

module lcd_draw_line (
    input  logic                sys_clk_50MHz,
    input  logic                sys_rst_n,
    input  logic                start_line,
    output lcd_pkg::lcd_word_t  word,
    output logic                req,
    input  logic                ack,
    output logic                line_done
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_REL} line_state_e;

    line_state_e state;
    logic [4:0]  step;
    logic [4:0]  pix_idx;

    assign pix_idx = step - 5'(lcd_pkg::SETUP_LEN);

    // one-row window around the line
    always_comb begin
        word.dc = 1'b1;
        case (step)
            5'd0:    begin word.dc = 1'b0; word.payload = lcd_pkg::CMD_CASET; end
            5'd2:    word.payload = lcd_pkg::LINE_X0;
            5'd4:    word.payload = lcd_pkg::LINE_X1;
            5'd5:    begin word.dc = 1'b0; word.payload = lcd_pkg::CMD_RASET; end
            5'd7:    word.payload = lcd_pkg::LINE_ROW;
            5'd9:    word.payload = lcd_pkg::LINE_ROW;
            5'd10:   begin word.dc = 1'b0; word.payload = lcd_pkg::CMD_RAMWR; end
            5'd1, 5'd3, 5'd6, 5'd8: word.payload = 8'h00;
            default: word.payload = pix_idx[0] ? lcd_pkg::LINE_COLOR[7:0]
                                               : lcd_pkg::LINE_COLOR[15:8];
        endcase
    end

    always_ff @(posedge sys_clk_50MHz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= ST_IDLE;
            step      <= '0;
            req       <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                ST_IDLE: if (start_line) begin
                    step  <= '0;
                    req   <= 1'b1;
                    state <= ST_REQ;
                end
                ST_REQ: if (ack) begin
                    req   <= 1'b0;
                    state <= ST_REL;
                end
                ST_REL: if (!ack) begin
                    if (step == 5'(lcd_pkg::LINE_WORDS - 1)) begin
                        line_done <= 1'b1;
                        state     <= ST_IDLE;
                    end else begin
                        step  <= step + 5'd1;
                        req   <= 1'b1;
                        state <= ST_REQ;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/lcd_control.sv ====
`timescale 1ns/1ns

module lcd_control (
    input  logic                sys_clk_50MHz,
    input  logic                sys_rst_n,
    input  lcd_pkg::lcd_word_t  init_word,
    input  lcd_pkg::lcd_word_t  pic_word,
    input  lcd_pkg::lcd_word_t  line_word,
    input  logic                init_req,
    input  logic                pic_req,
    input  logic                line_req,
    output logic                init_ack,
    output logic                pic_ack,
    output logic                line_ack,
    input  logic                init_done,
    input  logic                pic_done,
    input  logic                line_done,
    output logic                start_pic,
    output logic                start_line,
    output lcd_pkg::lcd_word_t  spi_word,
    output logic                spi_req,
    input  logic                spi_ack,
    output logic                led
);

    lcd_pkg::lcd_phase_e state, next_state;

    always_comb begin
        next_state = state;
        case (state)
            lcd_pkg::IDLE:      next_state = lcd_pkg::SHOW_PIC;   // next frame
            lcd_pkg::INIT:      if (init_done) next_state = lcd_pkg::SHOW_PIC;
            lcd_pkg::SHOW_PIC:  if (pic_done)  next_state = lcd_pkg::DRAW_LINE;
            lcd_pkg::DRAW_LINE: if (line_done) next_state = lcd_pkg::IDLE;
            default:            next_state = lcd_pkg::IDLE;
        endcase
    end

    // start pulses land in the first cycle of the new phase
    always_ff @(posedge sys_clk_50MHz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= lcd_pkg::INIT;
            start_pic  <= 1'b0;
            start_line <= 1'b0;
        end else begin
            state      <= next_state;
            start_pic  <= (next_state == lcd_pkg::SHOW_PIC)  && (state != lcd_pkg::SHOW_PIC);
            start_line <= (next_state == lcd_pkg::DRAW_LINE) && (state != lcd_pkg::DRAW_LINE);
        end
    end

    // ####################
    // output path mux
    always_comb begin
        spi_word = '0;
        spi_req  = 1'b0;
        init_ack = 1'b0;
        pic_ack  = 1'b0;
        line_ack = 1'b0;
        led      = 1'b1;
        case (state)
            lcd_pkg::INIT: begin
                spi_word = init_word;
                spi_req  = init_req;
                init_ack = spi_ack;
            end
            lcd_pkg::SHOW_PIC: begin
                spi_word = pic_word;
                spi_req  = pic_req;
                pic_ack  = spi_ack;
            end
            lcd_pkg::DRAW_LINE: begin
                spi_word = line_word;
                spi_req  = line_req;
                line_ack = spi_ack;
                led      = 1'b0;   // only low while the line goes out
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/spi_writer.sv ====
`timescale 1ns/1ns

module spi_writer (
    input  logic                sys_clk_50MHz,
    input  logic                sys_rst_n,
    input  lcd_pkg::lcd_word_t  word,
    input  logic                req,
    output logic                ack,
    output logic                lcd_sclk,
    output logic                lcd_mosi,
    output logic                lcd_dc,
    output logic                lcd_cs_n
);

    logic                busy;
    logic [3:0]          cnt;     // bit index in [3:1], sclk phase in [0]
    lcd_pkg::byte_t      shift;
    logic                accept;

    assign accept = req && !busy && !ack;

    // mode 0, sclk = clk/2
    assign lcd_cs_n = !busy;
    assign lcd_sclk = busy && cnt[0];
    assign lcd_mosi = busy && shift[7];   // msb first

    always_ff @(posedge sys_clk_50MHz or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            ack    <= 1'b0;
            lcd_dc <= 1'b0;
        end else if (accept) begin
            busy   <= 1'b1;
            cnt    <= '0;
            ack    <= 1'b1;
            lcd_dc <= word.dc;
        end else begin
            if (ack && !req)
                ack <= 1'b0;
            if (busy) begin
                cnt <= cnt + 4'd1;
                if (cnt == 4'd15)
                    busy <= 1'b0;   // 16 clocks per byte
            end
        end
    end

    // shift on falling sclk
    always_ff @(posedge sys_clk_50MHz) begin
        if (accept)
            shift <= word.payload;
        else if (busy && cnt[0])
            shift <= {shift[6:0], 1'b0};
    end

endmodule

// ==== verilog/lcd_top.sv ====
`timescale 1ns/1ns

module lcd_top (
    input  logic sys_clk_50MHz,
    input  logic sys_rst_n,
    output logic lcd_sclk,
    output logic lcd_mosi,
    output logic lcd_dc,
    output logic lcd_cs_n,
    output logic led
);

    lcd_pkg::lcd_word_t init_word, pic_word, line_word, spi_word;
    logic init_req, pic_req, line_req, spi_req;
    logic init_ack, pic_ack, line_ack, spi_ack;
    logic init_done, pic_done, line_done;
    logic start_pic, start_line;

    // ####################
    // word sources
    lcd_init i_lcd_init (
        .sys_clk_50MHz, .sys_rst_n,
        .word(init_word), .req(init_req), .ack(init_ack), .init_done
    );

    lcd_show_pic i_lcd_show_pic (
        .sys_clk_50MHz, .sys_rst_n, .start_pic,
        .word(pic_word), .req(pic_req), .ack(pic_ack), .pic_done
    );

    lcd_draw_line i_lcd_draw_line (
        .sys_clk_50MHz, .sys_rst_n, .start_line,
        .word(line_word), .req(line_req), .ack(line_ack), .line_done
    );

    // ####################
    // phase control and serializer
    lcd_control i_lcd_control (
        .sys_clk_50MHz, .sys_rst_n,
        .init_word, .pic_word, .line_word,
        .init_req, .pic_req, .line_req,
        .init_ack, .pic_ack, .line_ack,
        .init_done, .pic_done, .line_done,
        .start_pic, .start_line,
        .spi_word, .spi_req, .spi_ack,
        .led
    );

    spi_writer i_spi_writer (
        .sys_clk_50MHz, .sys_rst_n,
        .word(spi_word), .req(spi_req), .ack(spi_ack),
        .lcd_sclk, .lcd_mosi, .lcd_dc, .lcd_cs_n
    );

endmodule

// ==== tests/lcd_sva.sv ====
`timescale 1ns/1ns

module lcd_sva (
    input logic                sys_clk_50MHz,
    input logic                sys_rst_n,
    input logic                req,
    input logic                ack,
    input logic                cs_n,
    input lcd_pkg::lcd_phase_e state
);

    // ####################
    // four-phase handshake at the serializer
    req_held: assert property (@(posedge sys_clk_50MHz) disable iff (!sys_rst_n)
        req && !ack |=> req)
        else $error("req dropped before ack arrived");

    req_after_ack: assert property (@(posedge sys_clk_50MHz) disable iff (!sys_rst_n)
        $rose(req) |-> !ack)
        else $error("req raised again before ack fell");

    // 8 bits, 2 clocks each
    cs_frame: assert property (@(posedge sys_clk_50MHz) disable iff (!sys_rst_n)
        $fell(cs_n) |-> !cs_n [*16] ##1 cs_n)
        else $error("chip select low for other than 16 cycles");

    // phase changes only between handshakes
    phase_switch: assert property (@(posedge sys_clk_50MHz) disable iff (!sys_rst_n)
        $changed(state) |-> !req && !ack)
        else $error("controller phase changed with a handshake still open");

endmodule

bind lcd_top lcd_sva i_lcd_sva (
    .sys_clk_50MHz,
    .sys_rst_n,
    .req   (spi_req),
    .ack   (spi_ack),
    .cs_n  (lcd_cs_n),
    .state (i_lcd_control.state)
);

// ==== tests/tb_lcd_top.sv ====
`timescale 1ns/1ns

module tb_lcd_top;

    typedef struct packed {
        logic           dc;
        lcd_pkg::byte_t data;
        logic           led;
    } spi_byte_t;

    localparam int LINE_PIX   = int'(lcd_pkg::LINE_X1) - int'(lcd_pkg::LINE_X0) + 1;
    localparam int FRAME_LEN  = 11 + 2 * lcd_pkg::LCD_W * lcd_pkg::LCD_H + 11 + 2 * LINE_PIX;
    localparam int N_BYTES    = lcd_pkg::INIT_LEN + 2 * FRAME_LEN;   // two frames
    localparam int MAX_CYCLES = N_BYTES * 40 + 100;

    logic sys_clk_50MHz;
    logic sys_rst_n;
    logic lcd_sclk;
    logic lcd_mosi;
    logic lcd_dc;
    logic lcd_cs_n;
    logic led;

    spi_byte_t exp_tab [N_BYTES];
    spi_byte_t rx_tab  [N_BYTES];
    spi_byte_t rx_cur;
    int        exp_count;
    int        rx_count;
    int        bit_cnt;
    int        cycles;
    logic      sclk_q;
    logic      sclk_rise;

    lcd_top i_lcd_top (
        .sys_clk_50MHz, .sys_rst_n,
        .lcd_sclk, .lcd_mosi, .lcd_dc, .lcd_cs_n, .led
    );

    always #10 sys_clk_50MHz = ~sys_clk_50MHz;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ####################
    // expected byte table
    task automatic add_entry(input logic dc_exp, input lcd_pkg::byte_t data_exp,
                             input logic led_exp);
        exp_tab[exp_count] = '{dc: dc_exp, data: data_exp, led: led_exp};
        exp_count++;
    endtask

    // caset, raset, then ramwr
    task automatic add_window(input lcd_pkg::coord_t x0, input lcd_pkg::coord_t x1,
                              input lcd_pkg::coord_t y0, input lcd_pkg::coord_t y1,
                              input logic led_exp);
        add_entry(1'b0, lcd_pkg::CMD_CASET, led_exp);
        add_entry(1'b1, 8'h00, led_exp);
        add_entry(1'b1, x0, led_exp);
        add_entry(1'b1, 8'h00, led_exp);
        add_entry(1'b1, x1, led_exp);
        add_entry(1'b0, lcd_pkg::CMD_RASET, led_exp);
        add_entry(1'b1, 8'h00, led_exp);
        add_entry(1'b1, y0, led_exp);
        add_entry(1'b1, 8'h00, led_exp);
        add_entry(1'b1, y1, led_exp);
        add_entry(1'b0, lcd_pkg::CMD_RAMWR, led_exp);
    endtask

    task automatic add_pixels(input lcd_pkg::color_t color, input int count,
                              input logic led_exp);
        int p;
        for (p = 0; p < count; p++) begin
            add_entry(1'b1, color[15:8], led_exp);   // high byte first
            add_entry(1'b1, color[7:0], led_exp);
        end
    endtask

    task automatic build_table();
        int f;
        exp_count = 0;
        add_entry(1'b0, lcd_pkg::CMD_SWRESET, 1'b1);
        add_entry(1'b0, lcd_pkg::CMD_SLPOUT, 1'b1);
        add_entry(1'b0, lcd_pkg::CMD_COLMOD, 1'b1);
        add_entry(1'b1, lcd_pkg::COLMOD_16BIT, 1'b1);
        add_entry(1'b0, lcd_pkg::CMD_DISPON, 1'b1);
        for (f = 0; f < 2; f++) begin
            add_window(8'd0, lcd_pkg::coord_t'(lcd_pkg::LCD_W - 1),
                       8'd0, lcd_pkg::coord_t'(lcd_pkg::LCD_H - 1), 1'b1);
            add_pixels(lcd_pkg::BG_COLOR, lcd_pkg::LCD_W * lcd_pkg::LCD_H, 1'b1);
            add_window(lcd_pkg::LINE_X0, lcd_pkg::LINE_X1,
                       lcd_pkg::LINE_ROW, lcd_pkg::LINE_ROW, 1'b0);   // led low on the line
            add_pixels(lcd_pkg::LINE_COLOR, LINE_PIX, 1'b0);
        end
    endtask

    // ####################
    // spi receiver on the falling clock
    always @(negedge sys_clk_50MHz) begin
        sclk_rise = lcd_sclk && !sclk_q;
        sclk_q    = lcd_sclk;
        if (lcd_cs_n === 1'b1) begin
            if (bit_cnt != 0) begin
                $display("chip select went high after only %0d bits of a byte", bit_cnt);
                $display("ERRORS FOUND");
                $fatal(1, "spi byte cut short");
            end
        end else if (sclk_rise) begin
            if (bit_cnt == 0) begin
                rx_cur.dc  = lcd_dc;
                rx_cur.led = led;   // led as seen on the first bit
            end
            rx_cur.data = {rx_cur.data[6:0], lcd_mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                if (rx_count < N_BYTES)
                    rx_tab[rx_count] = rx_cur;
                rx_count++;
                bit_cnt = 0;
            end
        end
    end

    always @(posedge sys_clk_50MHz) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timed out after %0d cycles with %0d of %0d bytes received",
                     cycles, rx_count, N_BYTES);
            $display("ERRORS FOUND");
            $fatal(1, "simulation timeout");
        end
    end

    initial begin
        sys_clk_50MHz = 1'b0;
        sys_rst_n     = 1'b0;
        rx_cur        = '0;
        rx_count      = 0;
        bit_cnt       = 0;
        cycles        = 0;
        sclk_q        = 1'b0;
        sclk_rise     = 1'b0;
        build_table();

        repeat (3) @(negedge sys_clk_50MHz);
        check_value("lcd_cs_n", lcd_cs_n, 1'b1);
        check_value("led", led, 1'b1);
        sys_rst_n = 1'b1;

        for (int i = 0; i < N_BYTES; i++) begin
            while (rx_count <= i)
                @(negedge sys_clk_50MHz);
            check_value($sformatf("lcd_dc[%0d]", i), rx_tab[i].dc, exp_tab[i].dc);
            check_value($sformatf("lcd_mosi byte[%0d]", i), rx_tab[i].data, exp_tab[i].data);
            check_value($sformatf("led[%0d]", i), rx_tab[i].led, exp_tab[i].led);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/lcd_pkg.sv
verilog/lcd_init.sv
verilog/lcd_show_pic.sv
verilog/lcd_draw_line.sv
verilog/lcd_control.sv
verilog/spi_writer.sv
verilog/lcd_top.sv
tests/lcd_sva.sv
tests/tb_lcd_top.sv

// ==== Bender.yml ====
package:
  name: lcd_st7789

sources:
  - files:
      - verilog/lcd_pkg.sv
      - verilog/lcd_init.sv
      - verilog/lcd_show_pic.sv
      - verilog/lcd_draw_line.sv
      - verilog/lcd_control.sv
      - verilog/spi_writer.sv
      - verilog/lcd_top.sv

  - target: test
    files:
      - tests/lcd_sva.sv
      - tests/tb_lcd_top.sv
